// File: tb.f
rtl/calc_pkg.sv
rtl/calc_fsm.sv
rtl/step_counter.sv
rtl/operand_regs.sv
rtl/serial_addsub.sv
rtl/shift_add_mult.sv
rtl/calc_top.sv
verification/calc_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module calc_tb -o calc_sim

output=$(./obj_dir/calc_sim)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: verification/calc_tb.sv
`timescale 1ns/1ns

module calc_tb;
    import calc_pkg::*;

    localparam int directed_calcs = 7;
    localparam int random_calcs   = 20;
    localparam int total_calcs    = directed_calcs + random_calcs;
    localparam int cycle_limit    = total_calcs * 80 + 100;

    logic                  clk;
    logic                  nRST;
    logic [3:0]            key_digit;
    logic                  key_strobe;
    calc_op_t              op_code;
    logic                  op_strobe;
    logic                  equal_strobe;
    logic                  complete;
    logic [data_width-1:0] display_output;

    logic [31:0] lfsr    = 32'h6364_735b;
    int          cycles  = 0;
    int          issued  = 0;
    int          checked = 0;
    int          failed  = 0;
    int          errors  = 0;
    logic [15:0] expect_q[$];    // Expected display per calculation
    int          latency_q[$];
    int          edge_q[$];      // Edge number that samples equal
    string       label_q[$];

    calc_top calc_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .key_digit      (key_digit),
        .key_strobe     (key_strobe),
        .op_code        (op_code),
        .op_strobe      (op_strobe),
        .equal_strobe   (equal_strobe),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    always @(posedge clk) cycles = cycles + 1;

    initial begin : watchdog
        wait (cycles >= cycle_limit);
        $display("Timeout: run did not end within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int random_bits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // Ten times the operand plus the key, codes above 9 leave it alone
    function automatic logic [15:0] decimal_step(input logic [15:0] value, input logic [3:0] key);
        logic [31:0] wide;
        if (key > 4'd9) begin
            return value;
        end
        wide = 32'(value) * 32'd10 + 32'(key);
        return wide[15:0];
    endfunction

    function automatic logic [15:0] expected_result(input logic [15:0] a, input logic [15:0] b,
                                                    input calc_op_t op);
        logic [31:0] wide;
        case (op)
            op_add:  wide = 32'(a) + 32'(b);
            op_sub:  wide = 32'(a) - 32'(b);   // Negative wraps modulo 2^16
            default: wide = 32'(a) * 32'(b);
        endcase
        return wide[15:0];
    endfunction

    function automatic string op_symbol(input calc_op_t op);
        case (op)
            op_add:  return "+";
            op_sub:  return "-";
            default: return "*";
        endcase
    endfunction

    task automatic press_key(input logic [3:0] digit);
        @(negedge clk);
        key_digit  = digit;
        key_strobe = 1'b1;
        @(negedge clk);
        key_strobe = 1'b0;
    endtask

    task automatic press_op(input calc_op_t code);
        @(negedge clk);
        op_code   = code;
        op_strobe = 1'b1;
        @(negedge clk);
        op_strobe = 1'b0;
    endtask

    task automatic press_equal();
        @(negedge clk);
        equal_strobe = 1'b1;
        @(negedge clk);
        equal_strobe = 1'b0;
    endtask

    task automatic start_calc(input logic [15:0] expected, input int latency, input string label);
        expect_q.push_back(expected);
        latency_q.push_back(latency);
        label_q.push_back(label);
        @(negedge clk);
        edge_q.push_back(cycles + 1);   // Next rising edge samples equal
        equal_strobe = 1'b1;
        @(negedge clk);
        equal_strobe = 1'b0;
        issued++;
    endtask

    task automatic wait_result();
        wait (checked == issued);
        @(negedge clk);
    endtask

    task automatic enter_decimal(input int value, output logic [15:0] entered);
        int digits[10];
        int count;
        int rest;
        entered = '0;
        count   = 0;
        rest    = value;
        do begin
            digits[count] = rest % 10;
            rest          = rest / 10;
            count++;
        end while (rest != 0);
        for (int i = count - 1; i >= 0; i--) begin
            press_key(4'(digits[i]));   // Most significant digit first
            entered = decimal_step(entered, 4'(digits[i]));
        end
    endtask

    task automatic enter_random(output logic [15:0] entered);
        int count;
        int digit;
        entered = '0;
        count   = random_bits(3) % 5 + 1;
        for (int i = 0; i < count; i++) begin
            digit = random_bits(4) % 10;
            press_key(4'(digit));
            entered = decimal_step(entered, 4'(digit));
        end
    endtask

    task automatic calc_decimal(input int a_val, input calc_op_t op, input int b_val);
        logic [15:0] a;
        logic [15:0] b;
        enter_decimal(a_val, a);
        press_op(op);
        enter_decimal(b_val, b);
        start_calc(expected_result(a, b, op), (op == op_mul) ? 17 : 5,
                   $sformatf("%0d %s %0d", a_val, op_symbol(op), b_val));
        wait_result();
    endtask

    initial begin : compare_results
        logic        prev_complete;
        logic [15:0] expected;
        int          latency;
        int          start_edge;
        string       label;
        logic        ok;
        prev_complete = 1'b0;
        forever begin
            @(negedge clk);
            if (complete && !prev_complete) begin
                if (expect_q.size() == 0) begin
                    $display("complete rose at %0t ns with no calculation pending", $time);
                    errors++;
                end else begin
                    expected   = expect_q.pop_front();
                    latency    = latency_q.pop_front();
                    start_edge = edge_q.pop_front();
                    label      = label_q.pop_front();
                    ok         = 1'b1;
                    if (display_output !== expected) begin
                        $display("Error at %0t ns: display_output = %0d, expected %0d",
                                 $time, display_output, expected);
                        ok = 1'b0;
                    end
                    if (cycles - start_edge != latency) begin
                        $display("Error at %0t ns: complete rose after %0d edges, expected %0d",
                                 $time, cycles - start_edge, latency);
                        ok = 1'b0;
                    end
                    if (!ok) begin
                        errors++;
                        failed++;
                    end
                    $display("Test %0d: %s = %0d %s", checked + 1, label, display_output,
                             ok ? "ok" : "wrong");
                    checked++;
                end
            end
            prev_complete = complete;
        end
    end

    initial begin : stimulus
        logic [15:0] a;
        logic [15:0] b;
        calc_op_t    op;
        logic        ok;
        nRST         = 1'b0;
        key_digit    = 4'd0;
        key_strobe   = 1'b0;
        op_code      = op_none;
        op_strobe    = 1'b0;
        equal_strobe = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        ok = (complete === 1'b0) && (display_output === 16'd0);
        if (!ok) begin
            $display("Error at %0t ns: complete = %b, display_output = %0d, expected 0 and 0",
                     $time, complete, display_output);
            errors++;
        end
        $display("Test reset: outputs after reset %s", ok ? "ok" : "wrong");

        calc_decimal(12, op_add, 34);
        ok = 1'b1;
        repeat (6) begin   // Result must hold while no key arrives
            @(negedge clk);
            if (complete !== 1'b1 || display_output !== 16'd46) begin
                $display("Error at %0t ns: complete = %b, display_output = %0d, expected 1 and 46",
                         $time, complete, display_output);
                ok = 1'b0;
            end
        end
        press_key(4'd7);
        if (complete !== 1'b0) begin
            $display("Error at %0t ns: complete = %b, expected 0", $time, complete);
            ok = 1'b0;
        end
        if (!ok) begin
            errors++;
        end
        $display("Test hold: complete held and cleared by key %s", ok ? "ok" : "wrong");
        press_op(op_sub);   // Cleared operands give 7 - 3
        enter_decimal(3, b);
        start_calc(expected_result(16'd7, b, op_sub), 5, "7 - 3 after clear");
        wait_result();

        calc_decimal(65535, op_add, 1);
        calc_decimal(3, op_sub, 5);
        calc_decimal(300, op_mul, 300);

        // Odd key codes, bad operators and early equal
        a = '0;
        b = '0;
        press_key(4'd1);
        a = decimal_step(a, 4'd1);
        press_equal();
        press_key(4'd12);
        a = decimal_step(a, 4'd12);
        press_key(4'd5);
        a = decimal_step(a, 4'd5);
        press_op(calc_op_t'(3'b011));
        press_op(op_add);
        press_key(4'd7);
        b = decimal_step(b, 4'd7);
        press_op(op_mul);
        press_key(4'd15);
        b = decimal_step(b, 4'd15);
        press_key(4'd2);
        b = decimal_step(b, 4'd2);
        start_calc(expected_result(a, b, op_add), 5, "15 + 72 with ignored inputs");
        wait_result();

        // Strobes while the multiplier runs
        enter_decimal(25, a);
        press_op(op_mul);
        enter_decimal(4, b);
        start_calc(expected_result(a, b, op_mul), 17, "25 * 4 with strobes in run");
        press_key(4'd9);
        press_op(op_sub);
        press_equal();
        wait_result();

        for (int i = 0; i < random_calcs; i++) begin
            enter_random(a);
            case (random_bits(2) % 3)
                0:       op = op_add;
                1:       op = op_sub;
                default: op = op_mul;
            endcase
            press_op(op);
            enter_random(b);
            start_calc(expected_result(a, b, op), (op == op_mul) ? 17 : 5,
                       $sformatf("random %0d %s %0d", a, op_symbol(op), b));
            wait_result();
        end

        $display("Summary: %0d calculations, %0d failed, %0d errors in total",
                 checked, failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/calc_top.sv
`timescale 1ns/1ns

module calc_top (
    input  logic                             clk,
    input  logic                             nRST,
    input  logic [3:0]                       key_digit,
    input  logic                             key_strobe,
    input  calc_pkg::calc_op_t               op_code,
    input  logic                             op_strobe,
    input  logic                             equal_strobe,
    output logic                             complete,
    output logic [calc_pkg::data_width-1:0]  display_output
);
    import calc_pkg::*;

    operand_pair_t          operands;
    unit_ctrl_t             ctrl;
    logic                   capture_a;
    logic                   capture_b;
    logic                   clear;
    logic                   cnt_load;
    logic [count_width-1:0] cnt_value;
    logic                   busy;
    logic                   last;
    logic                   result_sel;
    logic                   show_load;
    logic [data_width-1:0]  add_result;
    logic [data_width-1:0]  mul_result;

    calc_fsm calc_fsm_i (
        .clk          (clk),
        .nRST         (nRST),
        .key_strobe   (key_strobe),
        .op_code      (op_code),
        .op_strobe    (op_strobe),
        .equal_strobe (equal_strobe),
        .last         (last),
        .capture_a    (capture_a),
        .capture_b    (capture_b),
        .clear        (clear),
        .ctrl         (ctrl),
        .cnt_load     (cnt_load),
        .cnt_value    (cnt_value),
        .result_sel   (result_sel),
        .show_load    (show_load),
        .complete     (complete)
    );

    step_counter step_counter_i (
        .clk   (clk),
        .nRST  (nRST),
        .load  (cnt_load),
        .count (cnt_value),
        .busy  (busy),
        .last  (last)
    );

    operand_regs operand_regs_i (
        .clk       (clk),
        .nRST      (nRST),
        .key_digit (key_digit),
        .capture_a (capture_a),
        .capture_b (capture_b),
        .clear     (clear),
        .operands  (operands)
    );

    // Both units step on busy, only the selected one is shown
    serial_addsub serial_addsub_i (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .load     (ctrl.load_add),
        .sub      (ctrl.sub),
        .step     (busy),
        .result   (add_result)
    );

    shift_add_mult shift_add_mult_i (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .load     (ctrl.load_mul),
        .step     (busy),
        .result   (mul_result)
    );

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
        end else if (show_load) begin
            display_output <= result_sel ? mul_result : add_result;
        end
    end

endmodule

// File: rtl/shift_add_mult.sv
`timescale 1ns/1ns

module shift_add_mult (
    input  logic                             clk,
    input  logic                             nRST,
    input  calc_pkg::operand_pair_t          operands,
    input  logic                             load,
    input  logic                             step,
    output logic [calc_pkg::data_width-1:0]  result
);
    import calc_pkg::*;

    logic [data_width-1:0] mcand;            // Shifts left once per step
    logic [data_width-1:0] mplier;           // Shifts right, bit 0 is current
    logic [data_width-1:0] product;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mcand   <= '0;
            mplier  <= '0;
            product <= '0;
        end else if (load) begin
            mcand   <= operands.a;
            mplier  <= operands.b;
            product <= '0;
        end else if (step) begin
            if (mplier[0]) begin
                product <= product + mcand;  // Partial product, low 16 bits only
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign result = product;

endmodule

// File: rtl/serial_addsub.sv
`timescale 1ns/1ns

module serial_addsub (
    input  logic                             clk,
    input  logic                             nRST,
    input  calc_pkg::operand_pair_t          operands,
    input  logic                             load,
    input  logic                             sub,
    input  logic                             step,
    output logic [calc_pkg::data_width-1:0]  result
);
    import calc_pkg::*;

    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] sum;
    logic                  carry;
    logic [4:0]            nibble_sum;       // Carry out plus four sum bits

    assign nibble_sum = {1'b0, op_a[3:0]} + {1'b0, op_b[3:0]} + {4'd0, carry};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_a  <= '0;
            op_b  <= '0;
            sum   <= '0;
            carry <= 1'b0;
        end else if (load) begin
            op_a  <= operands.a;
            op_b  <= sub ? ~operands.b : operands.b;   // a + ~b + 1 for a - b
            carry <= sub;
            sum   <= '0;
        end else if (step) begin
            sum   <= {nibble_sum[3:0], sum[data_width-1:4]};   // New nibble enters at top
            op_a  <= {op_a[3:0], op_a[data_width-1:4]};
            op_b  <= {op_b[3:0], op_b[data_width-1:4]};
            carry <= nibble_sum[4];
        end
    end

    // Four shifts bring the first nibble down to bit 0
    assign result = sum;

endmodule

// File: rtl/operand_regs.sv
`timescale 1ns/1ns

module operand_regs (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic [3:0]               key_digit,
    input  logic                     capture_a,
    input  logic                     capture_b,
    input  logic                     clear,
    output calc_pkg::operand_pair_t  operands
);
    import calc_pkg::*;

    operand_pair_t next_operands;
    logic          digit_ok;

    // Times ten as x*8 + x*2, then the new digit, wrapping at 16 bits
    function automatic logic [data_width-1:0] shift_in_digit(
        input logic [data_width-1:0] value,
        input logic [3:0]            digit
    );
        logic [data_width-1:0] times_ten;
        times_ten = (value << 3) + (value << 1);
        return times_ten + data_width'(digit);
    endfunction

    assign digit_ok = (key_digit <= 4'd9);   // Codes 10 to 15 are not digits

    always_comb begin
        next_operands = clear ? '0 : operands;   // Clear first, then capture
        if (digit_ok && capture_a) begin
            next_operands.a = shift_in_digit(next_operands.a, key_digit);
        end
        if (digit_ok && capture_b) begin
            next_operands.b = shift_in_digit(next_operands.b, key_digit);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operands <= '0;
        end else begin
            operands <= next_operands;
        end
    end

endmodule

// File: rtl/step_counter.sv
`timescale 1ns/1ns

module step_counter (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic                              load,
    input  logic [calc_pkg::count_width-1:0]  count,
    output logic                              busy,
    output logic                              last
);
    import calc_pkg::*;

    logic [count_width-1:0] remaining;     // Steps still to run

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count;
        end else if (busy) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign busy = (remaining != '0);
    assign last = (remaining == count_width'(1));   // Final step in progress

    // A new start while a unit is still stepping would corrupt its result
    a_no_load_busy: assert property (@(posedge clk) disable iff (!nRST)
        load |-> !busy);

endmodule

// File: rtl/calc_fsm.sv
`timescale 1ns/1ns

module calc_fsm (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic                              key_strobe,
    input  calc_pkg::calc_op_t                op_code,
    input  logic                              op_strobe,
    input  logic                              equal_strobe,
    input  logic                              last,
    output logic                              capture_a,
    output logic                              capture_b,
    output logic                              clear,
    output calc_pkg::unit_ctrl_t              ctrl,
    output logic                              cnt_load,
    output logic [calc_pkg::count_width-1:0]  cnt_value,
    output logic                              result_sel,
    output logic                              show_load,
    output logic                              complete
);
    import calc_pkg::*;

    calc_state_t state, next_state;
    calc_op_t    held_op, next_op;
    logic        op_valid;
    logic        start;
    logic        running;

    assign op_valid = op_strobe && (op_code inside {op_add, op_sub, op_mul});
    assign start    = (state == get_second) && equal_strobe;
    assign running  = (state == run_add) || (state == run_mul);

    always_comb begin
        next_state = state;
        next_op    = held_op;
        case (state)
            get_first: begin
                if (op_valid) begin
                    next_state = get_second;
                    next_op    = op_code;    // Operator ends operand a
                end
            end
            get_second: begin
                if (equal_strobe) begin
                    next_state = (held_op == op_mul) ? run_mul : run_add;
                end
            end
            run_add, run_mul: begin
                if (last) begin
                    next_state = show;
                end
            end
            show: begin
                if (key_strobe) begin
                    next_state = get_first;  // New entry starts from scratch
                    next_op    = op_none;
                end
            end
            default: next_state = get_first;
        endcase
    end

    // Entry enables, only outside the run states
    assign capture_a = key_strobe && ((state == get_first) || (state == show));
    assign capture_b = key_strobe && (state == get_second);
    assign clear     = key_strobe && (state == show);

    always_comb begin
        ctrl          = '0;
        ctrl.load_add = start && (held_op != op_mul);
        ctrl.load_mul = start && (held_op == op_mul);
        ctrl.sub      = (held_op == op_sub);
    end

    assign cnt_load   = start;
    assign cnt_value  = (held_op == op_mul) ? count_width'(mul_steps) : count_width'(add_steps);
    assign result_sel = (held_op == op_mul);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= get_first;
            held_op   <= op_none;
            show_load <= 1'b0;
            complete  <= 1'b0;
        end else begin
            state     <= next_state;
            held_op   <= next_op;
            show_load <= running && last;    // One pulse on entering show
            if (clear) begin
                complete <= 1'b0;
            end else if (show_load) begin
                complete <= 1'b1;
            end
        end
    end

    // The counter only reports a final step while a unit runs
    a_last_in_run: assert property (@(posedge clk) disable iff (!nRST)
        last |-> running);

    // Display load lands one cycle after the started unit's final step
    a_show_after_last: assert property (@(posedge clk) disable iff (!nRST)
        show_load |-> $past(ctrl.load_add, add_steps + 1) || $past(ctrl.load_mul, mul_steps + 1));

endmodule

// File: rtl/calc_pkg.sv
package calc_pkg;

    localparam int data_width  = 16;
    localparam int add_steps   = 4;    // One step per nibble
    localparam int mul_steps   = 16;   // One step per multiplier bit
    localparam int count_width = 5;    // Wide enough to hold mul_steps

    // Operator coding as seen on the keypad lines
    typedef enum logic [2:0] {
        op_none = 3'b000,              // No operator held
        op_add  = 3'b001,
        op_sub  = 3'b010,
        op_mul  = 3'b100
    } calc_op_t;

    typedef enum logic [2:0] {
        get_first,                     // Entering operand a
        get_second,                    // Entering operand b
        run_add,                       // Adder or subtractor busy
        run_mul,                       // Multiplier busy
        show                           // Result on display
    } calc_state_t;

    typedef struct packed {
        logic [data_width-1:0] a;      // First operand
        logic [data_width-1:0] b;      // Second operand
    } operand_pair_t;

    typedef struct packed {
        logic load_add;                // Start pulse for the adder
        logic load_mul;                // Start pulse for the multiplier
        logic sub;                     // Subtract select, valid with load_add
    } unit_ctrl_t;

endpackage
